// File: all.f
imgproc_pkg.sv
stream_reg.sv
color_classifier.sv
box_tracker.sv
video_overlay.sv
msg_fifo.sv
wb_regs.sv
imgproc_top.sv
tb_imgproc.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_imgproc
RTL_TOP    = imgproc_top
FILELIST   = all.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: tb_imgproc.sv
`timescale 1ns/1ns

module tb_imgproc;

	// the roughly 300 words at up to four cycles each plus bus cycles stay far below this
	localparam int TIMEOUT_CYCLES = 20000;

	localparam logic [23:0] OUTLINE_TEST = 24'h3c5a96;
	localparam logic [23:0] RED_PIX      = 24'hc83228;	// r 200 g 50 b 40
	localparam logic [23:0] BLUE_PIX     = 24'h143cb4;	// r 20 g 60 b 180

	logic        clk = 1'b0;
	logic        reset_n;
	logic        sink_valid_i;
	logic        sink_ready_o;
	logic [23:0] sink_data_i;
	logic        sink_sop_i;
	logic        sink_eop_i;
	logic        source_valid_o;
	logic        source_ready_i = 1'b1;
	logic [23:0] source_data_o;
	logic        source_sop_o;
	logic        source_eop_o;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [1:0]  wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;

	logic [25:0] tx_q [$];	// {rgb, sop, eop} still to send
	logic [25:0] exp_q [$];	// expected output words in order
	logic [31:0] pix_seed = 32'd78;
	logic [31:0] bp_seed  = 32'd78;
	logic        bp_on    = 1'b0;	// random source back-pressure
	int          cycle_count = 0;
	int          fail_count  = 0;

	imgproc_top imgproc_top_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.sink_valid_i   (sink_valid_i),
		.sink_ready_o   (sink_ready_o),
		.sink_data_i    (sink_data_i),
		.sink_sop_i     (sink_sop_i),
		.sink_eop_i     (sink_eop_i),
		.source_valid_o (source_valid_o),
		.source_ready_i (source_ready_i),
		.source_data_o  (source_data_o),
		.source_sop_o   (source_sop_o),
		.source_eop_o   (source_eop_o),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o)
	);

	always #2 clk = ~clk;

	////////////////////
	// helpers

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] next_byte();
		pix_seed = lcg_step(pix_seed);
		return pix_seed[23:16];
	endfunction

	// half green plus a quarter each of red and blue
	function automatic logic [23:0] grey_of(input logic [23:0] rgb);
		logic [7:0] g;
		g = (rgb[15:8] >> 1) + (rgb[23:16] >> 2) + (rgb[7:0] >> 2);
		return {g, g, g};
	endfunction

	task automatic stop_run(input string what);
		fail_count++;
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
		end
	endtask

	////////////////////
	// bus and stream

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = adr;
		wb_dat_i = dat;
		do @(negedge clk); while (!wb_ack_o);
		@(negedge clk);	// stb stays up over the edge that takes the ack
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = adr;
		do @(negedge clk); while (!wb_ack_o);
		dat = wb_dat_o;
		@(negedge clk);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
	endtask

	task automatic queue_word(input logic [23:0] rgb, input logic sop, input logic eop,
		input logic [23:0] exp_rgb);
		tx_q.push_back({rgb, sop, eop});
		exp_q.push_back({exp_rgb, sop, eop});
	endtask

	task automatic send_words();
		logic [25:0] w;
		while (tx_q.size() > 0) begin
			w = tx_q.pop_front();
			@(negedge clk);
			sink_valid_i = 1'b1;
			{sink_data_i, sink_sop_i, sink_eop_i} = w;
			do @(posedge clk); while (!sink_ready_o);	// taken on this edge
		end
		@(negedge clk);
		sink_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() > 0)
			@(negedge clk);
	endtask

	// video frame of equal-channel pixels that never trigger a detection
	task automatic send_frame(input int len, input logic overlay, input logic boxes);
		logic [7:0]  v;
		logic [23:0] rgb;
		logic [23:0] exp_rgb;
		queue_word(24'h000000, 1'b1, 1'b0, 24'h000000);
		for (int x = 0; x < len; x++) begin
			v = next_byte();
			rgb = {v, v, v};
			if (!overlay)
				exp_rgb = rgb;
			else if (boxes && (x == 13 || x == 19 || x == 28))
				exp_rgb = OUTLINE_TEST;	// box edges of the overlay frame
			else
				exp_rgb = grey_of(rgb);
			queue_word(rgb, 1'b0, x == len - 1, exp_rgb);
		end
		send_words();
	endtask

	always @(negedge clk) begin
		bp_seed = lcg_step(bp_seed);
		source_ready_i = bp_on ? (bp_seed[29:28] != 2'b00) : 1'b1;	// ready 3 of 4
	end

	// output monitor sees the handshake as it stood before the edge
	always @(posedge clk) begin
		logic [25:0] exp_word;
		if (reset_n && source_valid_o && source_ready_i) begin
			assert (exp_q.size() > 0) else begin
				stop_run("an output word arrived when no word was expected");
			end
			if (exp_q.size() > 0) begin
				exp_word = exp_q.pop_front();
				assert (source_data_o === exp_word[25:2]) else begin
					stop_run($sformatf("FAIL source_data_o got %h expected %h",
						source_data_o, exp_word[25:2]));
				end
				assert ({source_sop_o, source_eop_o} === exp_word[1:0]) else begin
					stop_run($sformatf("FAIL source_sop_o/source_eop_o got %h expected %h",
						{source_sop_o, source_eop_o}, exp_word[1:0]));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_run("timeout, the tests did not finish within the cycle limit");
	end

	////////////////////
	// tests

	task automatic read_back_registers();
		logic [31:0] data;
		wb_read(imgproc_pkg::ADDR_ID, data);
		check_value("wb_dat_o (id)", data, imgproc_pkg::CORE_ID);
		wb_read(imgproc_pkg::ADDR_STATUS, data);
		check_value("wb_dat_o (status)", data, 32'h0);
		wb_read(imgproc_pkg::ADDR_OUTLINE, data);
		check_value("wb_dat_o (outline)", data, {8'h0, imgproc_pkg::OUTLINE_DEFAULT});
		wb_write(imgproc_pkg::ADDR_OUTLINE, {8'h0, OUTLINE_TEST});
		wb_read(imgproc_pkg::ADDR_OUTLINE, data);
		check_value("wb_dat_o (outline)", data, {8'h0, OUTLINE_TEST});
	endtask

	task automatic pass_random_frames();
		logic [23:0] rgb;
		int          len;
		bp_on = 1'b1;
		for (int f = 0; f < 6; f++) begin
			len = 4 + int'(next_byte() % 8'd13);
			rgb = {next_byte(), next_byte(), next_byte()};	// packet type is random too
			queue_word(rgb, 1'b1, 1'b0, rgb);
			for (int i = 0; i < len; i++) begin
				rgb = {next_byte(), next_byte(), next_byte()};
				queue_word(rgb, 1'b0, i == len - 1, rgb);
			end
			send_words();
		end
		send_frame(16, 1'b0, 1'b0);	// leaves both boxes not found
		wait_drain();
		wb_write(imgproc_pkg::ADDR_STATUS, 32'h10);	// drop messages from random frames
	endtask

	task automatic draw_overlay_frame();
		logic [7:0]  v;
		logic [23:0] rgb;
		logic [23:0] exp_rgb;
		wb_write(imgproc_pkg::ADDR_STATUS, 32'h1);
		queue_word(24'h123450, 1'b1, 1'b0, 24'h123450);	// blue low nibble 0 makes it video
		for (int x = 0; x < 32; x++) begin
			v = next_byte();
			if (x >= 10 && x <= 19)
				rgb = RED_PIX;
			else if (x >= 25 && x <= 28)
				rgb = BLUE_PIX;
			else
				rgb = {v, v, v};
			// hits start on the fourth detection in a row
			if (x >= 13 && x <= 19)
				exp_rgb = imgproc_pkg::FILL_RED;
			else if (x == 28)
				exp_rgb = imgproc_pkg::FILL_BLUE;
			else
				exp_rgb = grey_of(rgb);
			queue_word(rgb, 1'b0, x == 31, exp_rgb);
		end
		queue_word(24'h000005, 1'b1, 1'b0, 24'h000005);	// non-video packet
		for (int i = 0; i < 8; i++)
			queue_word(RED_PIX, 1'b0, i == 7, RED_PIX);
		send_words();
		wait_drain();
	endtask

	task automatic read_frame_messages();
		logic [31:0] data;
		wb_read(imgproc_pkg::ADDR_STATUS, data);
		check_value("wb_dat_o[15:8] (fifo count)", {24'h0, data[15:8]}, 32'd2);
		wb_read(imgproc_pkg::ADDR_MSG, data);
		check_value("wb_dat_o (red message)", data,
			(32'(imgproc_pkg::MSG_ID_RED) << 24) | (32'd1 << 23) | (32'd13 << 11) | 32'd19);
		wb_read(imgproc_pkg::ADDR_MSG, data);
		check_value("wb_dat_o (blue message)", data,
			(32'(imgproc_pkg::MSG_ID_BLUE) << 24) | (32'd1 << 23) | (32'd28 << 11) | 32'd28);
		wb_read(imgproc_pkg::ADDR_STATUS, data);
		check_value("wb_dat_o[15:8] (fifo count)", {24'h0, data[15:8]}, 32'd0);
	endtask

	task automatic draw_box_outlines();
		send_frame(32, 1'b1, 1'b1);
		wait_drain();
	endtask

	task automatic flush_and_fill_fifo();
		logic [31:0] data;
		wb_write(imgproc_pkg::ADDR_STATUS, 32'h11);	// flush with enable kept on
		wb_read(imgproc_pkg::ADDR_STATUS, data);
		check_value("wb_dat_o (status)", data, 32'h1);
		repeat (10)
			send_frame(8, 1'b1, 1'b0);
		wait_drain();
		wb_read(imgproc_pkg::ADDR_STATUS, data);
		check_value("wb_dat_o (status)", data, 32'h1001);	// count 16 and enable
		// the first frame after the flush had no hits
		wb_read(imgproc_pkg::ADDR_MSG, data);
		check_value("wb_dat_o (red message)", data, 32'(imgproc_pkg::MSG_ID_RED) << 24);
	endtask

	initial begin
		reset_n      = 1'b0;
		sink_valid_i = 1'b0;
		sink_data_i  = '0;
		sink_sop_i   = 1'b0;
		sink_eop_i   = 1'b0;
		wb_cyc_i     = 1'b0;
		wb_stb_i     = 1'b0;
		wb_we_i      = 1'b0;
		wb_adr_i     = '0;
		wb_dat_i     = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		read_back_registers();
		pass_random_frames();
		draw_overlay_frame();
		read_frame_messages();
		draw_box_outlines();
		flush_and_fill_fifo();

		if (fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: imgproc_top.sv
`timescale 1ns/1ns

module imgproc_top (
	input  logic        clk,
	input  logic        reset_n,

	// stream sink
	input  logic        sink_valid_i,
	output logic        sink_ready_o,
	input  logic [23:0] sink_data_i,
	input  logic        sink_sop_i,
	input  logic        sink_eop_i,

	// stream source
	output logic        source_valid_o,
	input  logic        source_ready_i,
	output logic [23:0] source_data_o,
	output logic        source_sop_o,
	output logic        source_eop_o,

	// wishbone slave
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [1:0]  wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o
);

	logic [31:0]                   msg;
	logic                          msg_push;
	logic [31:0]                   fifo_data;
	logic [imgproc_pkg::CNT_W-1:0] fifo_count;
	logic                          fifo_empty;
	logic                          fifo_pop;
	logic                          fifo_flush;
	logic                          enable;
	logic [23:0]                   outline;

	////////////////////
	// producer

	video_overlay video_overlay_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.sink_valid_i   (sink_valid_i),
		.sink_ready_o   (sink_ready_o),
		.sink_data_i    (sink_data_i),
		.sink_sop_i     (sink_sop_i),
		.sink_eop_i     (sink_eop_i),
		.source_valid_o (source_valid_o),
		.source_ready_i (source_ready_i),
		.source_data_o  (source_data_o),
		.source_sop_o   (source_sop_o),
		.source_eop_o   (source_eop_o),
		.enable_i       (enable),
		.outline_i      (outline),
		.fifo_count_i   (fifo_count),
		.msg_o          (msg),
		.msg_push_o     (msg_push)
	);

	////////////////////
	// buffer

	msg_fifo msg_fifo_i (
		.clk     (clk),
		.reset_n (reset_n),
		.push_i  (msg_push),
		.data_i  (msg),
		.pop_i   (fifo_pop),
		.flush_i (fifo_flush),
		.data_o  (fifo_data),
		.count_o (fifo_count),
		.empty_o (fifo_empty)
	);

	////////////////////
	// consumer

	wb_regs wb_regs_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.fifo_data_i  (fifo_data),
		.fifo_count_i (fifo_count),
		.fifo_empty_i (fifo_empty),
		.fifo_pop_o   (fifo_pop),
		.fifo_flush_o (fifo_flush),
		.enable_o     (enable),
		.outline_o    (outline)
	);

endmodule

// File: wb_regs.sv
`timescale 1ns/1ns

module wb_regs (
	input  logic                          clk,
	input  logic                          reset_n,

	// wishbone classic slave
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	input  logic                          wb_we_i,
	input  logic [1:0]                    wb_adr_i,
	input  logic [31:0]                   wb_dat_i,
	output logic [31:0]                   wb_dat_o,
	output logic                          wb_ack_o,

	// message FIFO
	input  logic [31:0]                   fifo_data_i,
	input  logic [imgproc_pkg::CNT_W-1:0] fifo_count_i,
	input  logic                          fifo_empty_i,
	output logic                          fifo_pop_o,
	output logic                          fifo_flush_o,

	// to the overlay
	output logic                          enable_o,
	output logic [23:0]                   outline_o
);

	logic req;
	logic rd_req;
	logic wr_req;

	// new cycle seen, ack follows on the next edge
	assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign rd_req = req && !wb_we_i;
	assign wr_req = req && wb_we_i;

	// both strobes land on the edge that raises ack
	assign fifo_pop_o   = rd_req && (wb_adr_i == imgproc_pkg::ADDR_MSG) && !fifo_empty_i;
	assign fifo_flush_o = wr_req && (wb_adr_i == imgproc_pkg::ADDR_STATUS) &&
		wb_dat_i[imgproc_pkg::FLUSH_BIT];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_ack_o  <= 1'b0;
			enable_o  <= 1'b0;
			outline_o <= imgproc_pkg::OUTLINE_DEFAULT;
		end else begin
			wb_ack_o <= req;	// one cycle wide
			if (wr_req) begin
				case (wb_adr_i)
					imgproc_pkg::ADDR_STATUS:  enable_o  <= wb_dat_i[imgproc_pkg::ENABLE_BIT];
					imgproc_pkg::ADDR_OUTLINE: outline_o <= wb_dat_i[23:0];
					default:                   ;	// msg and id are read only
				endcase
			end
		end
	end

	////////////////////
	// read data, registered with ack

	always_ff @(posedge clk) begin
		if (rd_req) begin
			case (wb_adr_i)
				imgproc_pkg::ADDR_STATUS:
					wb_dat_o <= {16'h0, {(8 - imgproc_pkg::CNT_W){1'b0}}, fifo_count_i,
						7'h0, enable_o};
				imgproc_pkg::ADDR_MSG:
					wb_dat_o <= fifo_empty_i ? 32'h0 : fifo_data_i;
				imgproc_pkg::ADDR_ID:
					wb_dat_o <= imgproc_pkg::CORE_ID;
				default:
					wb_dat_o <= {8'h0, outline_o};
			endcase
		end
	end

	// master keeps stb up until it has seen the ack
	a_ack_needs_stb: assert property (@(posedge clk) disable iff (!reset_n)
		wb_ack_o |-> wb_stb_i);

endmodule

// File: msg_fifo.sv
`timescale 1ns/1ns

module msg_fifo (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          push_i,
	input  logic [31:0]                   data_i,
	input  logic                          pop_i,
	input  logic                          flush_i,
	output logic [31:0]                   data_o,	// head word, valid when not empty
	output logic [imgproc_pkg::CNT_W-1:0] count_o,
	output logic                          empty_o
);

	localparam int PTR_W = $clog2(imgproc_pkg::MSG_DEPTH);

	logic [31:0]      mem [imgproc_pkg::MSG_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full    = (int'(count_o) == imgproc_pkg::MSG_DEPTH);
	assign empty_o = (count_o == '0);

	// guarded strobes
	assign wr_en = push_i && !full;
	assign rd_en = pop_i && !empty_o;

	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else if (flush_i) begin	// beats a push on the same edge
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two, pointers wrap
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= data_i;
	end

	// the producer checks for room before it starts a message pair
	a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
		push_i |-> !full);

	// the bus side only pops a non-empty buffer
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
		pop_i |-> !empty_o);

endmodule

// File: video_overlay.sv
`timescale 1ns/1ns

module video_overlay (
	input  logic                            clk,
	input  logic                            reset_n,

	// stream sink
	input  logic                            sink_valid_i,
	output logic                            sink_ready_o,
	input  logic [23:0]                     sink_data_i,
	input  logic                            sink_sop_i,
	input  logic                            sink_eop_i,

	// stream source
	output logic                            source_valid_o,
	input  logic                            source_ready_i,
	output logic [23:0]                     source_data_o,
	output logic                            source_sop_o,
	output logic                            source_eop_o,

	// control from the register block
	input  logic                            enable_i,
	input  logic [23:0]                     outline_i,

	// message side
	input  logic [imgproc_pkg::CNT_W-1:0]   fifo_count_i,
	output logic [31:0]                     msg_o,
	output logic                            msg_push_o
);

	imgproc_pkg::pixel_word_t in_word;
	imgproc_pkg::pixel_word_t s1_word;
	imgproc_pkg::pixel_word_t out_word;
	imgproc_pkg::pixel_word_t s2_word;
	logic                s1_valid;
	logic                s2_ready;
	logic                accept;
	imgproc_pkg::coord_t x_q;
	logic                packet_video;
	logic                video_now;
	logic                frame_end;
	logic                red_hit;
	logic                blue_hit;
	logic                red_found;
	logic                blue_found;
	imgproc_pkg::coord_t red_left;
	imgproc_pkg::coord_t red_right;
	imgproc_pkg::coord_t blue_left;
	imgproc_pkg::coord_t blue_right;
	logic                red_edge;
	logic                blue_edge;
	logic                overlay_on;
	logic [7:0]          grey;
	logic [23:0]         new_rgb;
	logic [23:0]         out_rgb;
	logic                frame_done_q;
	logic                push_red;
	logic                push_blue_q;

	function automatic logic [31:0] pack_msg(logic [7:0] tag, logic found,
		imgproc_pkg::coord_t left, imgproc_pkg::coord_t right);
		return {tag, found, 1'b0, left, right};
	endfunction

	assign in_word = {sink_data_i, sink_sop_i, sink_eop_i};

	stream_reg in_reg (
		.clk     (clk),
		.reset_n (reset_n),
		.valid_i (sink_valid_i),
		.ready_o (sink_ready_o),
		.data_i  (in_word),
		.valid_o (s1_valid),
		.ready_i (s2_ready),
		.data_o  (s1_word)
	);

	// everything below acts on s1_word and commits when it moves on
	assign accept = s1_valid && s2_ready;

	////////////////////
	// coordinates and packet type

	// the sop word carries its own type before packet_video catches up
	assign video_now = s1_word.sop ? (s1_word.blue[3:0] == 4'h0) : packet_video;
	assign frame_end = accept && s1_word.eop && video_now;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x_q          <= '0;
			packet_video <= 1'b0;
		end else if (accept) begin
			if (s1_word.sop) begin
				x_q          <= '0;
				packet_video <= (s1_word.blue[3:0] == 4'h0);
			end else if (int'(x_q) == imgproc_pkg::IMAGE_W - 1) begin
				x_q <= '0;	// next line
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	////////////////////
	// detection and boxes

	color_classifier classifier_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.pixel_i    (s1_word),
		.advance_i  (accept),
		.red_hit_o  (red_hit),
		.blue_hit_o (blue_hit)
	);

	box_tracker red_box_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.advance_i   (accept),
		.frame_end_i (frame_end),
		.hit_i       (red_hit && video_now && !s1_word.sop),
		.x_i         (x_q),
		.found_o     (red_found),
		.left_o      (red_left),
		.right_o     (red_right)
	);

	box_tracker blue_box_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.advance_i   (accept),
		.frame_end_i (frame_end),
		.hit_i       (blue_hit && video_now && !s1_word.sop),
		.x_i         (x_q),
		.found_o     (blue_found),
		.left_o      (blue_left),
		.right_o     (blue_right)
	);

	////////////////////
	// overlay mux

	// boxes are from the previous frame
	assign red_edge  = red_found && (x_q == red_left || x_q == red_right);
	assign blue_edge = blue_found && (x_q == blue_left || x_q == blue_right);

	assign grey = s1_word.green[7:1] + s1_word.red[7:2] + s1_word.blue[7:2];

	always_comb begin
		if (red_edge || blue_edge)
			new_rgb = outline_i;
		else if (red_hit)
			new_rgb = imgproc_pkg::FILL_RED;
		else if (blue_hit)
			new_rgb = imgproc_pkg::FILL_BLUE;
		else
			new_rgb = {grey, grey, grey};
	end

	// sop descriptor and non-video packets go through as they are
	assign overlay_on = enable_i && packet_video && !s1_word.sop;
	assign out_rgb    = overlay_on ? new_rgb : {s1_word.red, s1_word.green, s1_word.blue};
	assign out_word   = {out_rgb, s1_word.sop, s1_word.eop};

	stream_reg out_reg (
		.clk     (clk),
		.reset_n (reset_n),
		.valid_i (s1_valid),
		.ready_o (s2_ready),
		.data_i  (out_word),
		.valid_o (source_valid_o),
		.ready_i (source_ready_i),
		.data_o  (s2_word)
	);

	assign {source_data_o, source_sop_o, source_eop_o} = s2_word;

	////////////////////
	// message push, red then blue

	// both words need room, else the frame is skipped
	assign push_red = frame_done_q && (int'(fifo_count_i) <= imgproc_pkg::MSG_DEPTH - 2);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_done_q <= 1'b0;
			push_blue_q  <= 1'b0;
		end else begin
			frame_done_q <= frame_end;
			push_blue_q  <= push_red;
		end
	end

	assign msg_push_o = push_red || push_blue_q;
	assign msg_o = push_blue_q ?
		pack_msg(imgproc_pkg::MSG_ID_BLUE, blue_found, blue_left, blue_right) :
		pack_msg(imgproc_pkg::MSG_ID_RED, red_found, red_left, red_right);

endmodule

// File: box_tracker.sv
`timescale 1ns/1ns

module box_tracker (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                advance_i,	// pixel accepted
	input  logic                frame_end_i,	// accepted video eop
	input  logic                hit_i,
	input  imgproc_pkg::coord_t x_i,
	output logic                found_o,
	output imgproc_pkg::coord_t left_o,
	output imgproc_pkg::coord_t right_o
);

	logic                seen_q;
	logic                seen_nxt;
	logic                upd;
	imgproc_pkg::coord_t min_q;
	imgproc_pkg::coord_t max_q;
	imgproc_pkg::coord_t min_nxt;
	imgproc_pkg::coord_t max_nxt;

	assign upd = advance_i && hit_i;

	// running values including the current pixel, so the eop pixel counts too
	assign seen_nxt = seen_q || upd;
	assign min_nxt  = (upd && (!seen_q || x_i < min_q)) ? x_i : min_q;
	assign max_nxt  = (upd && (!seen_q || x_i > max_q)) ? x_i : max_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			seen_q  <= 1'b0;
			found_o <= 1'b0;
			left_o  <= '0;
			right_o <= '0;
		end else if (frame_end_i) begin
			found_o <= seen_nxt;
			left_o  <= seen_nxt ? min_nxt : '0;
			right_o <= seen_nxt ? max_nxt : '0;
			seen_q  <= 1'b0;	// start the next frame empty
		end else begin
			seen_q <= seen_nxt;
		end
	end

	// min/max only mean something while seen_q is set
	always_ff @(posedge clk) begin
		min_q <= min_nxt;
		max_q <= max_nxt;
	end

endmodule

// File: color_classifier.sv
`timescale 1ns/1ns

module color_classifier (
	input  logic                     clk,
	input  logic                     reset_n,
	input  imgproc_pkg::pixel_word_t pixel_i,
	input  logic                     advance_i,	// pixel accepted this cycle
	output logic                     red_hit_o,
	output logic                     blue_hit_o
);

	logic [8:0] r9;
	logic [8:0] g9;
	logic [8:0] b9;
	logic       red_det;
	logic       blue_det;
	logic [imgproc_pkg::RUN_LEN-2:0] red_hist;	// newest detection in bit 0
	logic [imgproc_pkg::RUN_LEN-2:0] blue_hist;

	// one spare bit so the margin sums cannot wrap
	assign r9 = {1'b0, pixel_i.red};
	assign g9 = {1'b0, pixel_i.green};
	assign b9 = {1'b0, pixel_i.blue};

	assign red_det = (r9 > g9 + 9'(imgproc_pkg::RED_MARGIN)) &&
		(r9 > b9 + 9'(imgproc_pkg::RED_MARGIN));

	assign blue_det = (b9 + 9'(imgproc_pkg::BLUE_SLACK) > g9) && (b9 > r9) && !red_det;

	// a hit needs this pixel and every pixel in the history
	assign red_hit_o  = red_det && (&red_hist);
	assign blue_hit_o = blue_det && (&blue_hist);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			red_hist  <= '0;
			blue_hist <= '0;
		end else if (advance_i) begin
			if (pixel_i.sop) begin	// new packet, forget the old run
				red_hist  <= '0;
				blue_hist <= '0;
			end else begin
				red_hist  <= {red_hist[imgproc_pkg::RUN_LEN-3:0], red_det};
				blue_hist <= {blue_hist[imgproc_pkg::RUN_LEN-3:0], blue_det};
			end
		end
	end

endmodule

// File: stream_reg.sv
`timescale 1ns/1ns

module stream_reg (
	input  logic                     clk,
	input  logic                     reset_n,

	// upstream side
	input  logic                     valid_i,
	output logic                     ready_o,
	input  imgproc_pkg::pixel_word_t data_i,

	// downstream side
	output logic                     valid_o,
	input  logic                     ready_i,
	output imgproc_pkg::pixel_word_t data_o
);

	// take a word when empty or when the held word leaves this cycle
	assign ready_o = !valid_o || ready_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_o <= 1'b0;
		end else if (ready_o) begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (ready_o && valid_i) begin
			data_o <= data_i;	// payload only
		end
	end

	// the upstream must hold a stalled word until this stage takes it
	a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
		valid_i && !ready_o |=> valid_i && $stable(data_i));

endmodule

// File: imgproc_pkg.sv
package imgproc_pkg;

	////////////////////
	// stream word

	typedef logic [7:0] pix_t;	// one colour channel

	typedef struct packed {
		pix_t red;
		pix_t green;
		pix_t blue;
		logic sop;
		logic eop;
	} pixel_word_t;	// 26 bits on the stream

	////////////////////
	// geometry

	localparam int X_W     = 11;
	localparam int IMAGE_W = 640;	// x wraps here

	typedef logic [X_W-1:0] coord_t;

	////////////////////
	// classifier thresholds

	localparam int RUN_LEN    = 4;	// detections in a row before a hit
	localparam int RED_MARGIN = 30;
	localparam int BLUE_SLACK = 20;

	////////////////////
	// overlay colours

	localparam logic [23:0] FILL_RED        = 24'hff0000;
	localparam logic [23:0] FILL_BLUE       = 24'h0000ff;
	localparam logic [23:0] OUTLINE_DEFAULT = 24'h00ff00;

	////////////////////
	// message FIFO and tags

	localparam int MSG_DEPTH = 16;
	localparam int CNT_W     = 5;	// holds 0..MSG_DEPTH

	localparam logic [7:0] MSG_ID_RED  = 8'h01;
	localparam logic [7:0] MSG_ID_BLUE = 8'h02;

	////////////////////
	// register map, word addresses

	localparam logic [1:0] ADDR_STATUS  = 2'd0;
	localparam logic [1:0] ADDR_MSG     = 2'd1;
	localparam logic [1:0] ADDR_ID      = 2'd2;
	localparam logic [1:0] ADDR_OUTLINE = 2'd3;

	localparam logic [31:0] CORE_ID = 32'h1234eee2;

	// status register bits
	localparam int FLUSH_BIT  = 4;	// write only, reads as 0
	localparam int ENABLE_BIT = 0;

endpackage
